// ==== hdl/frontend_defines.svh ====
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Datapath widths
`define ADDR_LEN 32
`define INSN_LEN 32

// Architectural register index, x0..x31
`define REG_SEL 5

// PC loaded on reset
`define ENTRY_POINT 32'h0000_0200

// One aligned fetch holds two instructions
`define FETCH_BYTES 8

`endif

// ==== hdl/frontend_pkg.sv ====
`include "frontend_defines.svh"

package frontend_pkg;

   // RV32I major opcodes, inst[6:0]
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011
   } opcode_e;

   // Reservation station class
   typedef enum logic [1:0] {
      UNIT_NONE   = 2'd0,
      UNIT_ALU    = 2'd1,
      UNIT_BRANCH = 2'd2,
      UNIT_MEM    = 2'd3
   } unit_e;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SLT  = 4'd3,
      ALU_SLTU = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SRA  = 4'd7,
      ALU_OR   = 4'd8,
      ALU_AND  = 4'd9
   } alu_op_e;

   typedef enum logic [2:0] {
      IMM_I = 3'd0,
      IMM_S = 3'd1,
      IMM_B = 3'd2,
      IMM_U = 3'd3,
      IMM_J = 3'd4
   } imm_type_e;

   // One decoded instruction
   typedef struct packed {
      logic [`REG_SEL-1:0] rd;
      logic [`REG_SEL-1:0] rs1;
      logic [`REG_SEL-1:0] rs2;
      logic                uses_rs1;
      logic                uses_rs2;
      logic                wr_reg;    // Low when rd is x0
      unit_e               unit;
      alu_op_e             alu_op;
      imm_type_e           imm_type;
      logic                illegal;
   } decoded_inst_t;

   // Fetch buffer contents
   typedef struct packed {
      logic [`ADDR_LEN-1:0] pc;
      logic [`INSN_LEN-1:0] inst1;
      logic [`INSN_LEN-1:0] inst2;
      logic                 valid1;
      logic                 valid2;
   } fetch_pair_t;

   // Dispatch latch contents
   typedef struct packed {
      logic [`ADDR_LEN-1:0] pc;
      decoded_inst_t        slot1;
      decoded_inst_t        slot2;
      logic                 valid1;
      logic                 valid2;
      logic                 rs1_2_eq_dst1;  // Slot 2 rs1 reads slot 1 rd
      logic                 rs2_2_eq_dst1;
      logic [`ADDR_LEN-1:0] next_addr1;     // Fall-through of slot 1
      logic [`ADDR_LEN-1:0] next_addr2;
   } dispatch_pair_t;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/100ps
`include "frontend_defines.svh"

module fetch_stage (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      stall,
   input  logic                      redirect,
   input  logic [`ADDR_LEN-1:0]      redirect_addr,
   input  logic [2*`INSN_LEN-1:0]    idata,
   output logic [`ADDR_LEN-1:0]      pc,
   output frontend_pkg::fetch_pair_t fetched
);

   localparam int unsigned INSN_BYTES = `INSN_LEN / 8;

   logic [`ADDR_LEN-1:0] next_pc;
   logic                 odd_word;   // PC points at the upper half of a pair
   logic [`INSN_LEN-1:0] lo_word;
   logic [`INSN_LEN-1:0] hi_word;

   assign odd_word = pc[2];
   assign lo_word  = idata[`INSN_LEN-1:0];
   assign hi_word  = idata[2*`INSN_LEN-1:`INSN_LEN];

   // No prediction, always sequential
   assign next_pc = odd_word ? (pc + INSN_BYTES) : (pc + `FETCH_BYTES);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `ENTRY_POINT;
      end else if (redirect) begin
         pc <= redirect_addr;
      end else if (!stall) begin
         pc <= next_pc;
      end
   end

   // Instruction pair buffer
   always_ff @(posedge clk) begin
      if (reset || redirect) begin
         fetched.valid1 <= 1'b0;
         fetched.valid2 <= 1'b0;
      end else if (!stall) begin
         fetched.pc     <= pc;
         fetched.inst1  <= odd_word ? hi_word : lo_word;  // Single insn lands in slot 1
         fetched.inst2  <= hi_word;
         fetched.valid1 <= 1'b1;
         fetched.valid2 <= !odd_word;
      end
   end

endmodule

// ==== hdl/rv32_decoder.sv ====
`timescale 1ns/100ps
`include "frontend_defines.svh"

// Combinational RV32I decode, one instruction
module rv32_decoder (
   input  logic [`INSN_LEN-1:0]        inst,
   output frontend_pkg::decoded_inst_t decoded
);

   frontend_pkg::opcode_e opcode;
   logic [2:0]            funct3;
   logic                  alt;      // funct7 bit 5, sub and sra
   logic                  writes;   // Format has an rd, before the x0 check

   // Register-register and immediate ALU ops share funct3 coding
   function automatic frontend_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                             input logic       sub_ok,
                                                             input logic       alt_bit);
      frontend_pkg::alu_op_e op;
      case (f3)
         3'b000:  op = (sub_ok && alt_bit) ? frontend_pkg::ALU_SUB : frontend_pkg::ALU_ADD;
         3'b001:  op = frontend_pkg::ALU_SLL;
         3'b010:  op = frontend_pkg::ALU_SLT;
         3'b011:  op = frontend_pkg::ALU_SLTU;
         3'b100:  op = frontend_pkg::ALU_XOR;
         3'b101:  op = alt_bit ? frontend_pkg::ALU_SRA : frontend_pkg::ALU_SRL;
         3'b110:  op = frontend_pkg::ALU_OR;
         default: op = frontend_pkg::ALU_AND;
      endcase
      return op;
   endfunction

   // Compare used by each branch condition
   function automatic frontend_pkg::alu_op_e branch_cmp(input logic [2:0] f3);
      frontend_pkg::alu_op_e op;
      case (f3[2:1])
         2'b00:   op = frontend_pkg::ALU_SUB;   // beq, bne
         2'b10:   op = frontend_pkg::ALU_SLT;   // blt, bge
         default: op = frontend_pkg::ALU_SLTU;  // bltu, bgeu
      endcase
      return op;
   endfunction

   assign opcode = frontend_pkg::opcode_e'(inst[6:0]);
   assign funct3 = inst[14:12];
   assign alt    = inst[30];

   always_comb begin
      // Field positions are fixed across formats
      decoded.rd       = inst[11:7];
      decoded.rs1      = inst[19:15];
      decoded.rs2      = inst[24:20];
      decoded.uses_rs1 = 1'b0;
      decoded.uses_rs2 = 1'b0;
      decoded.unit     = frontend_pkg::UNIT_NONE;
      decoded.alu_op   = frontend_pkg::ALU_ADD;
      decoded.imm_type = frontend_pkg::IMM_I;
      decoded.illegal  = 1'b0;
      writes           = 1'b0;

      case (opcode)
         frontend_pkg::OPC_LUI,
         frontend_pkg::OPC_AUIPC: begin
            writes           = 1'b1;
            decoded.unit     = frontend_pkg::UNIT_ALU;
            decoded.imm_type = frontend_pkg::IMM_U;
         end
         frontend_pkg::OPC_JAL: begin
            writes           = 1'b1;  // Link register
            decoded.unit     = frontend_pkg::UNIT_BRANCH;
            decoded.imm_type = frontend_pkg::IMM_J;
         end
         frontend_pkg::OPC_JALR: begin
            writes           = 1'b1;
            decoded.uses_rs1 = 1'b1;
            decoded.unit     = frontend_pkg::UNIT_BRANCH;
         end
         frontend_pkg::OPC_BRANCH: begin
            decoded.uses_rs1 = 1'b1;
            decoded.uses_rs2 = 1'b1;
            decoded.unit     = frontend_pkg::UNIT_BRANCH;
            decoded.alu_op   = branch_cmp(funct3);
            decoded.imm_type = frontend_pkg::IMM_B;
         end
         frontend_pkg::OPC_LOAD: begin
            writes           = 1'b1;
            decoded.uses_rs1 = 1'b1;
            decoded.unit     = frontend_pkg::UNIT_MEM;  // Address add
         end
         frontend_pkg::OPC_STORE: begin
            decoded.uses_rs1 = 1'b1;
            decoded.uses_rs2 = 1'b1;  // Store data
            decoded.unit     = frontend_pkg::UNIT_MEM;
            decoded.imm_type = frontend_pkg::IMM_S;
         end
         frontend_pkg::OPC_OP_IMM: begin
            writes           = 1'b1;
            decoded.uses_rs1 = 1'b1;
            decoded.unit     = frontend_pkg::UNIT_ALU;
            decoded.alu_op   = alu_from_funct3(funct3, 1'b0, alt);  // No subi
         end
         frontend_pkg::OPC_OP: begin
            writes           = 1'b1;
            decoded.uses_rs1 = 1'b1;
            decoded.uses_rs2 = 1'b1;
            decoded.unit     = frontend_pkg::UNIT_ALU;
            decoded.alu_op   = alu_from_funct3(funct3, 1'b1, alt);
         end
         default: begin
            decoded.illegal = 1'b1;
         end
      endcase

      // Writes to x0 are dropped
      decoded.wr_reg = writes && (inst[11:7] != '0);
   end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/100ps
`include "frontend_defines.svh"

module decode_stage (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         stall,
   input  logic                         redirect,
   input  frontend_pkg::fetch_pair_t    fetched,
   output frontend_pkg::dispatch_pair_t dispatch
);

   localparam int unsigned INSN_BYTES = `INSN_LEN / 8;

   frontend_pkg::decoded_inst_t  dec1;
   frontend_pkg::decoded_inst_t  dec2;
   frontend_pkg::dispatch_pair_t next_dispatch;

   rv32_decoder u_dec1 (
      .inst    (fetched.inst1),
      .decoded (dec1)
   );

   rv32_decoder u_dec2 (
      .inst    (fetched.inst2),
      .decoded (dec2)
   );

   always_comb begin
      next_dispatch.pc     = fetched.pc;
      next_dispatch.slot1  = dec1;
      next_dispatch.slot2  = dec2;
      next_dispatch.valid1 = fetched.valid1;
      next_dispatch.valid2 = fetched.valid2;

      // Empty slot goes to no unit
      if (!fetched.valid1) begin
         next_dispatch.slot1.unit = frontend_pkg::UNIT_NONE;
      end
      if (!fetched.valid2) begin
         next_dispatch.slot2.unit = frontend_pkg::UNIT_NONE;
      end

      // Intra-pair RAW on slot 1 destination
      next_dispatch.rs1_2_eq_dst1 = dec1.wr_reg && (dec2.rs1 == dec1.rd);
      next_dispatch.rs2_2_eq_dst1 = dec1.wr_reg && (dec2.rs2 == dec1.rd);

      next_dispatch.next_addr1 = fetched.pc + INSN_BYTES;
      next_dispatch.next_addr2 = fetched.pc + `FETCH_BYTES;
   end

   // Dispatch latch
   always_ff @(posedge clk) begin
      if (reset || redirect) begin
         dispatch.valid1 <= 1'b0;
         dispatch.valid2 <= 1'b0;
      end else if (!stall) begin
         dispatch <= next_dispatch;
      end
   end

endmodule

// ==== hdl/frontend_top.sv ====
`timescale 1ns/100ps
`include "frontend_defines.svh"

// Two-wide front end, fetch then decode
module frontend_top (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [2*`INSN_LEN-1:0]       idata,         // {pc+4 word, pc word}
   input  logic                         stall,
   input  logic                         redirect,      // Resolved mispredict pulse
   input  logic [`ADDR_LEN-1:0]         redirect_addr,
   output logic [`ADDR_LEN-1:0]         pc,
   output frontend_pkg::dispatch_pair_t dispatch
);

   frontend_pkg::fetch_pair_t fetched;

   fetch_stage u_fetch (
      .clk           (clk),
      .reset         (reset),
      .stall         (stall),
      .redirect      (redirect),
      .redirect_addr (redirect_addr),
      .idata         (idata),
      .pc            (pc),
      .fetched       (fetched)
   );

   decode_stage u_decode (
      .clk      (clk),
      .reset    (reset),
      .stall    (stall),
      .redirect (redirect),
      .fetched  (fetched),
      .dispatch (dispatch)
   );

endmodule

// ==== testbench/tb_frontend_table.svh ====
`ifndef TB_FRONTEND_TABLE_SVH
`define TB_FRONTEND_TABLE_SVH

// Row k sits at ENTRY_POINT + 8*k, inst1 low word, inst2 high word
// Expected fields: rd, rs1, rs2, uses_rs1, uses_rs2, wr_reg, unit, alu_op, imm_type, illegal

localparam int NUM_ROWS = 8;

typedef struct packed {
   logic [31:0]                 inst1;
   logic [31:0]                 inst2;
   frontend_pkg::decoded_inst_t exp1;
   frontend_pkg::decoded_inst_t exp2;
} row_t;

localparam row_t ROWS [NUM_ROWS] = '{
   // add x1,x2,x3 then sub x4,x1,x5
   '{32'h003100b3, 32'h40508233,
     '{5'd1, 5'd2, 5'd3, 1'b1, 1'b1, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_ADD, frontend_pkg::IMM_I, 1'b0},
     '{5'd4, 5'd1, 5'd5, 1'b1, 1'b1, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_SUB, frontend_pkg::IMM_I, 1'b0}},
   // addi x0,x7,5 then xor x8,x0,x0
   '{32'h00538013, 32'h00004433,
     '{5'd0, 5'd7, 5'd5, 1'b1, 1'b0, 1'b0,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_ADD, frontend_pkg::IMM_I, 1'b0},
     '{5'd8, 5'd0, 5'd0, 1'b1, 1'b1, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_XOR, frontend_pkg::IMM_I, 1'b0}},
   // lw x9,8(x2) then sw x9,4(x9)
   '{32'h00812483, 32'h0094a223,
     '{5'd9, 5'd2, 5'd8, 1'b1, 1'b0, 1'b1,
       frontend_pkg::UNIT_MEM, frontend_pkg::ALU_ADD, frontend_pkg::IMM_I, 1'b0},
     '{5'd4, 5'd9, 5'd9, 1'b1, 1'b1, 1'b0,
       frontend_pkg::UNIT_MEM, frontend_pkg::ALU_ADD, frontend_pkg::IMM_S, 1'b0}},
   // lui x10,1 then auipc x11,2
   '{32'h00001537, 32'h00002597,
     '{5'd10, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_ADD, frontend_pkg::IMM_U, 1'b0},
     '{5'd11, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_ADD, frontend_pkg::IMM_U, 1'b0}},
   // jal x1,16 then jalr x0,0(x1)
   '{32'h010000ef, 32'h00008067,
     '{5'd1, 5'd0, 5'd16, 1'b0, 1'b0, 1'b1,
       frontend_pkg::UNIT_BRANCH, frontend_pkg::ALU_ADD, frontend_pkg::IMM_J, 1'b0},
     '{5'd0, 5'd1, 5'd0, 1'b1, 1'b0, 1'b0,
       frontend_pkg::UNIT_BRANCH, frontend_pkg::ALU_ADD, frontend_pkg::IMM_I, 1'b0}},
   // beq x3,x4,8 then bgeu x5,x6,12
   '{32'h00418463, 32'h0062f663,
     '{5'd8, 5'd3, 5'd4, 1'b1, 1'b1, 1'b0,
       frontend_pkg::UNIT_BRANCH, frontend_pkg::ALU_SUB, frontend_pkg::IMM_B, 1'b0},
     '{5'd12, 5'd5, 5'd6, 1'b1, 1'b1, 1'b0,
       frontend_pkg::UNIT_BRANCH, frontend_pkg::ALU_SLTU, frontend_pkg::IMM_B, 1'b0}},
   // Unknown opcode then srai x12,x12,3
   '{32'hffffffff, 32'h40365613,
     '{5'd31, 5'd31, 5'd31, 1'b0, 1'b0, 1'b0,
       frontend_pkg::UNIT_NONE, frontend_pkg::ALU_ADD, frontend_pkg::IMM_I, 1'b1},
     '{5'd12, 5'd12, 5'd3, 1'b1, 1'b0, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_SRA, frontend_pkg::IMM_I, 1'b0}},
   // slt x13,x14,x15 then and x16,x15,x13
   '{32'h00f726b3, 32'h00d7f833,
     '{5'd13, 5'd14, 5'd15, 1'b1, 1'b1, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_SLT, frontend_pkg::IMM_I, 1'b0},
     '{5'd16, 5'd15, 5'd13, 1'b1, 1'b1, 1'b1,
       frontend_pkg::UNIT_ALU, frontend_pkg::ALU_AND, frontend_pkg::IMM_I, 1'b0}}
};

`endif

// ==== testbench/tb_frontend.sv ====
`timescale 1ns/100ps
`include "frontend_defines.svh"

module tb_frontend;

   localparam real CLK_PERIOD = 100.0;
   localparam int  MEM_WORDS  = 256;

   `include "tb_frontend_table.svh"

   logic                         clk = 1'b0;
   logic                         reset;
   logic                         stall;
   logic                         redirect;
   logic [`ADDR_LEN-1:0]         redirect_addr;
   logic [2*`INSN_LEN-1:0]       idata;
   logic [`ADDR_LEN-1:0]         pc;
   frontend_pkg::dispatch_pair_t dispatch;

   logic [31:0] prog [MEM_WORDS];
   integer      seed = 32'hdb5b_d62d;
   int          seen [NUM_ROWS];
   int          checks = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          tests = 0;
   int          failed_tests = 0;

   // Reference pipeline state
   logic [31:0] m_pc;
   logic [31:0] b_pc;
   logic        b_v1;
   logic        b_v2;
   logic [31:0] d_pc;
   logic        d_v1;
   logic        d_v2;

   frontend_top u_dut (
      .clk           (clk),
      .reset         (reset),
      .idata         (idata),
      .stall         (stall),
      .redirect      (redirect),
      .redirect_addr (redirect_addr),
      .pc            (pc),
      .dispatch      (dispatch)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Aligned pair for the current pc
   always_comb begin
      idata = {prog[{pc[9:3], 1'b1}], prog[{pc[9:3], 1'b0}]};
   end

   task automatic expect_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic check_slots();
      logic [31:0] offset;
      int          row;
      frontend_pkg::decoded_inst_t e1;
      frontend_pkg::decoded_inst_t e2;
      offset = d_pc - `ENTRY_POINT;
      if (offset < NUM_ROWS * 8) begin
         row = int'(offset >> 3);
         e1  = d_pc[2] ? ROWS[row].exp2 : ROWS[row].exp1;  // Odd fetch holds only the high word
         e2  = ROWS[row].exp2;
         expect_value("slot1", 64'(dispatch.slot1), 64'(e1));
         if (d_v2) begin
            expect_value("slot2", 64'(dispatch.slot2), 64'(e2));
            expect_value("rs1_2_eq_dst1", 64'(dispatch.rs1_2_eq_dst1),
                         64'(e1.wr_reg && e2.rs1 == e1.rd));
            expect_value("rs2_2_eq_dst1", 64'(dispatch.rs2_2_eq_dst1),
                         64'(e1.wr_reg && e2.rs2 == e1.rd));
         end
      end
   endtask

   // Row taken from the pc the DUT shows when its latch loads
   task automatic count_dispatched(input logic loaded);
      logic [31:0] offset;
      offset = dispatch.pc - `ENTRY_POINT;
      if (loaded && dispatch.valid2 === 1'b1 && offset < NUM_ROWS * 8) begin
         seen[offset >> 3]++;
      end
   endtask

   task automatic compare_outputs(input logic loaded);
      expect_value("pc", 64'(pc), 64'(m_pc));
      expect_value("valid1", 64'(dispatch.valid1), 64'(d_v1));
      expect_value("valid2", 64'(dispatch.valid2), 64'(d_v2));
      if (d_v1) begin
         expect_value("dispatch pc", 64'(dispatch.pc), 64'(d_pc));
         expect_value("next_addr1", 64'(dispatch.next_addr1), 64'(d_pc + 32'd4));
         expect_value("next_addr2", 64'(dispatch.next_addr2), 64'(d_pc + 32'd8));
         check_slots();
      end
      // Empty slots go to no unit
      if (loaded && !d_v1) begin
         expect_value("empty slot1 unit", 64'(dispatch.slot1.unit),
                      64'(frontend_pkg::UNIT_NONE));
      end
      if (d_v1 && !d_v2) begin
         expect_value("empty slot2 unit", 64'(dispatch.slot2.unit),
                      64'(frontend_pkg::UNIT_NONE));
      end
      count_dispatched(loaded);
   endtask

   // Drive at the falling edge then advance the model and compare
   task automatic step(input logic stall_v, input logic redirect_v, input logic [31:0] target);
      logic loaded;
      stall         = stall_v;
      redirect      = redirect_v;
      redirect_addr = target;
      @(negedge clk);
      loaded = 1'b0;
      if (redirect_v) begin
         d_v1 = 1'b0;
         d_v2 = 1'b0;
         b_v1 = 1'b0;
         b_v2 = 1'b0;
         m_pc = target;
      end else if (!stall_v) begin
         d_pc   = b_pc;
         d_v1   = b_v1;
         d_v2   = b_v2;
         b_pc   = m_pc;
         b_v1   = 1'b1;
         b_v2   = !m_pc[2];
         m_pc   = m_pc + (m_pc[2] ? 32'd4 : 32'd8);
         loaded = 1'b1;
      end
      compare_outputs(loaded);
   endtask

   task automatic close_test(input string name);
      $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
      tests++;
      if (test_errors != 0) begin
         failed_tests++;
      end
      test_errors = 0;
   endtask

   task automatic clear_seen();
      foreach (seen[i]) begin
         seen[i] = 0;
      end
   endtask

   initial begin
      int n;
      reset         = 1'b1;
      stall         = 1'b0;
      redirect      = 1'b0;
      redirect_addr = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         prog[i] = 32'hc3c3_0000 ^ (i * 4);  // Filler tied to byte address
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         prog[(`ENTRY_POINT >> 2) + 2 * r]     = ROWS[r].inst1;
         prog[(`ENTRY_POINT >> 2) + 2 * r + 1] = ROWS[r].inst2;
      end
      m_pc = `ENTRY_POINT;
      b_pc = '0;
      b_v1 = 1'b0;
      b_v2 = 1'b0;
      d_pc = '0;
      d_v1 = 1'b0;
      d_v2 = 1'b0;
      clear_seen();

      repeat (8) @(posedge clk);
      @(negedge clk);
      compare_outputs(1'b0);
      reset = 1'b0;
      close_test("reset");

      // Whole table with no stall plus two cycles of latency
      for (int r = 0; r < NUM_ROWS + 2; r++) begin
         step(1'b0, 1'b0, '0);
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         expect_value("times row dispatched", 64'(seen[r]), 64'd1);
      end
      close_test("sequential");

      step(1'b0, 1'b1, `ENTRY_POINT);
      clear_seen();
      n = 0;
      while (seen[NUM_ROWS-1] == 0 && n < NUM_ROWS * 8) begin
         step(($unsigned($random(seed)) % 3) == 0, 1'b0, '0);
         n++;
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         expect_value("times row dispatched under stall", 64'(seen[r]), 64'd1);
      end
      close_test("stall");

      step(1'b0, 1'b1, `ENTRY_POINT + 4);
      expect_value("pc after redirect", 64'(pc), 64'(`ENTRY_POINT + 4));
      step(1'b0, 1'b0, '0);
      expect_value("pc after odd fetch", 64'(pc), 64'(`ENTRY_POINT + 8));
      expect_value("valid1 flushed", 64'(dispatch.valid1), 64'd0);
      step(1'b0, 1'b0, '0);
      expect_value("pc pair step", 64'(pc), 64'(`ENTRY_POINT + 16));
      expect_value("odd valid1", 64'(dispatch.valid1), 64'd1);
      expect_value("odd valid2", 64'(dispatch.valid2), 64'd0);
      expect_value("odd dispatch pc", 64'(dispatch.pc), 64'(`ENTRY_POINT + 4));
      step(1'b0, 1'b0, '0);
      close_test("redirect");

      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests, checks,
               errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Watchdog allows 20 cycles per table row
   initial begin
      #(NUM_ROWS * 20 * CLK_PERIOD);
      $display("Simulation timed out before the tests completed");
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+hdl
+incdir+testbench
hdl/frontend_pkg.sv
hdl/fetch_stage.sv
hdl/rv32_decoder.sv
hdl/decode_stage.sv
hdl/frontend_top.sv
testbench/tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the front end testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_frontend \
   -Mdir obj_dir -o tb_frontend &&
./obj_dir/tb_frontend > sim.log 2>&1 ||
{ echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
